//--- source/filter_cond_pkg.sv
// --------------------
// Shared widths, packet and configuration types for the filter-condition engine
// Imported by every RTL module of the engine and by its testbench
// --------------------
`default_nettype none

package filter_cond_pkg;

    // --------------------
    // Widths and depths
    // --------------------
    localparam int DATA_W      = 32;
    localparam int ID_W        = 8;
    localparam int ADDR_W      = 16;
    localparam int COUNT_W     = 16;
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;

    // Pointer and fill widths, depth is a power of two
    localparam int                  FIFO_PTR_W      = $clog2(FIFO_DEPTH);
    localparam logic [FIFO_PTR_W:0] FIFO_FULL_LEVEL = FIFO_DEPTH[FIFO_PTR_W:0];
    localparam logic [FIFO_PTR_W:0] FIFO_PROG_LEVEL = PROG_THRESH[FIFO_PTR_W:0];

    // --------------------
    // Data word and operator
    // --------------------
    // Same bits, read either way depending on signed_cmp
    typedef union packed {
        logic        [DATA_W-1:0] u;
        logic signed [DATA_W-1:0] s;
    } data_word_t;

    typedef enum logic [1:0] {
        CMP_EQ = 2'd0,
        CMP_NE = 2'd1,
        CMP_LT = 2'd2,
        CMP_GT = 2'd3
    } cmp_op_t;

    // --------------------
    // Packets
    // --------------------
    typedef struct packed {
        logic [ID_W-1:0]   to;
        logic [ID_W-1:0]   from;
        logic [ADDR_W-1:0] address;
    } packet_meta_t;

    typedef struct packed {
        packet_meta_t meta;
        data_word_t   data;
    } packet_payload_t;

    typedef struct packed {
        logic            valid;
        packet_payload_t payload;
    } mem_packet_t;

    // --------------------
    // Job control
    // --------------------
    typedef struct packed {
        cmp_op_t         op;
        logic            signed_cmp;
        data_word_t      value;
        logic            conditional_flag;
        logic [ID_W-1:0] if_id;
        logic [ID_W-1:0] else_id;
    } filter_param_t;

    typedef struct packed {
        logic          valid;
        filter_param_t param;
    } filter_config_t;

    typedef struct packed {
        logic               valid;
        logic [COUNT_W-1:0] count;
    } descriptor_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic prog_full;
    } fifo_flags_t;

endpackage

`default_nettype wire

//--- source/packet_fifo.sv
// --------------------
// Synchronous FIFO for packet payloads
// Output valid follows a read by one cycle, prog_full tracks the fill level
// --------------------
`timescale 1ns/1ps
`default_nettype none

module packet_fifo (
    input  logic                             ap_clk,
    input  logic                             areset_generator,
    input  logic                             wr_en,
    input  filter_cond_pkg::packet_payload_t din,
    input  logic                             rd_en,
    output filter_cond_pkg::mem_packet_t     dout,
    output filter_cond_pkg::fifo_flags_t     flags
);
    import filter_cond_pkg::*;

    packet_payload_t       mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   fill;
    logic                  do_write;
    logic                  do_read;

    assign do_write = wr_en & ~flags.full;
    assign do_read  = rd_en & ~flags.empty;

    assign flags.empty     = (fill == '0);
    assign flags.full      = (fill == FIFO_FULL_LEVEL);
    assign flags.prog_full = (fill >= FIFO_PROG_LEVEL);

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap on their own
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Read data with its valid one cycle after the pop
    always_ff @(posedge ap_clk) begin
        dout.valid <= do_read;
        if (do_read) begin
            dout.payload <= mem[rd_ptr];
        end
        if (areset_generator) begin
            dout.valid <= 1'b0;
        end
    end

    // Producer must watch full, consumer must watch empty
    a_no_write_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator) wr_en |-> !flags.full)
        else $error("packet_fifo write while full");

    a_no_read_empty: assert property (
        @(posedge ap_clk) disable iff (areset_generator) rd_en |-> !flags.empty)
        else $error("packet_fifo read while empty");

endmodule

`default_nettype wire

//--- source/filter_cond_control.sv
// --------------------
// Job control for the filter-condition engine
// Requests the configuration, paces input pops and reports done
// --------------------
`timescale 1ns/1ps
`default_nettype none

module filter_cond_control (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  filter_cond_pkg::descriptor_t    descriptor,
    input  logic                            config_ready,
    input  filter_cond_pkg::filter_config_t cfg,
    input  filter_cond_pkg::fifo_flags_t    in_flags,
    input  filter_cond_pkg::fifo_flags_t    out_flags,
    input  logic                            kernel_valid,
    input  logic                            route_valid,
    input  logic                            popped_valid,
    output logic                            configure_setup,
    output filter_cond_pkg::filter_param_t  param,
    output logic                            param_valid,
    output logic                            pop,
    output logic                            done
);
    import filter_cond_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETUP_REQ,
        ST_SETUP_WAIT,
        ST_BUSY,
        ST_DONE
    } ctrl_state_t;

    ctrl_state_t        state;
    logic [COUNT_W-1:0] job_count;
    logic [COUNT_W-1:0] pop_count;
    logic               count_reached;
    logic               pipe_empty;
    logic               job_start;

    assign count_reached = (pop_count == job_count);
    assign pipe_empty    = ~pop & ~popped_valid & ~kernel_valid & ~route_valid;
    assign job_start     = descriptor.valid & ((state == ST_IDLE) | (state == ST_DONE));

    // Hold off while the output side is nearly full
    assign pop = (state == ST_BUSY) & ~in_flags.empty & ~out_flags.prog_full & ~count_reached;

    // --------------------
    // Job FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state           <= ST_IDLE;
            configure_setup <= 1'b0;
            param_valid     <= 1'b0;
            done            <= 1'b0;
            job_count       <= '0;
            pop_count       <= '0;
        end else begin
            configure_setup <= 1'b0;
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (job_start) begin
                        state       <= ST_SETUP_REQ;
                        done        <= 1'b0;
                        param_valid <= 1'b0;
                        job_count   <= descriptor.count;
                        pop_count   <= '0;
                    end
                end
                ST_SETUP_REQ: begin
                    // Single request pulse, then wait for the answer
                    if (config_ready) begin
                        configure_setup <= 1'b1;
                        state           <= ST_SETUP_WAIT;
                    end
                end
                ST_SETUP_WAIT: begin
                    if (cfg.valid) begin
                        param_valid <= 1'b1;
                        state       <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (pop) begin
                        pop_count <= pop_count + 1'b1;
                    end
                    // Last packet has left the route stage
                    if (count_reached && pipe_empty) begin
                        done  <= 1'b1;
                        state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Parameters latched once per job
    always_ff @(posedge ap_clk) begin
        if (state == ST_SETUP_WAIT && cfg.valid) begin
            param <= cfg.param;
        end
    end

    // Configuration words only answer a pending request
    a_config_after_request: assert property (
        @(posedge ap_clk) disable iff (areset_generator) cfg.valid |-> (state == ST_SETUP_WAIT))
        else $error("configuration word arrived outside the setup wait");

endmodule

`default_nettype wire

//--- source/filter_cond_kernel.sv
// --------------------
// Compare stage of the filter-condition engine
// Registers the packet together with its pass/fail flag
// --------------------
`timescale 1ns/1ps
`default_nettype none

module filter_cond_kernel (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  filter_cond_pkg::filter_param_t param,
    input  filter_cond_pkg::mem_packet_t   in_pkt,
    output filter_cond_pkg::mem_packet_t   out_pkt,
    output logic                           result_flag
);
    import filter_cond_pkg::*;

    logic is_eq;
    logic is_lt;
    logic pass;

    always_comb begin
        is_eq = (in_pkt.payload.data.u == param.value.u);
        // Signed view only when the job asks for it
        if (param.signed_cmp) begin
            is_lt = (in_pkt.payload.data.s < param.value.s);
        end else begin
            is_lt = (in_pkt.payload.data.u < param.value.u);
        end
        case (param.op)
            CMP_EQ:  pass = is_eq;
            CMP_NE:  pass = ~is_eq;
            CMP_LT:  pass = is_lt;
            default: pass = ~is_lt & ~is_eq;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        out_pkt     <= in_pkt;
        result_flag <= pass;
        if (areset_generator) begin
            out_pkt.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/filter_cond_route.sv
// --------------------
// Route stage of the filter-condition engine
// Drops failing packets or rewrites the destination, then writes the output FIFO
// --------------------
`timescale 1ns/1ps
`default_nettype none

module filter_cond_route (
    input  logic                             ap_clk,
    input  logic                             areset_generator,
    input  filter_cond_pkg::filter_param_t   param,
    input  filter_cond_pkg::mem_packet_t     in_pkt,
    input  logic                             result_flag,
    output logic                             wr_en,
    output filter_cond_pkg::packet_payload_t dout
);
    import filter_cond_pkg::*;

    logic            keep;
    logic [ID_W-1:0] next_to;

    // Conditional mode keeps everything
    assign keep = param.conditional_flag | result_flag;

    always_comb begin
        if (!param.conditional_flag) begin
            next_to = in_pkt.payload.meta.to;
        end else if (result_flag) begin
            next_to = param.if_id;
        end else begin
            next_to = param.else_id;
        end
    end

    // --------------------
    // Output FIFO write
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= in_pkt.valid & keep;
        end
    end

    // Data, address and source pass through
    always_ff @(posedge ap_clk) begin
        dout         <= in_pkt.payload;
        dout.meta.to <= next_to;
    end

endmodule

`default_nettype wire

//--- source/engine_filter_cond_generator.sv
// --------------------
// Filter-condition engine top level
// Registers the inputs and connects the FIFOs, control, compare and route stages
// --------------------
`timescale 1ns/1ps
`default_nettype none

module engine_filter_cond_generator (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  filter_cond_pkg::descriptor_t    descriptor_in,
    input  logic                            config_ready,
    input  filter_cond_pkg::filter_config_t config_in,
    input  filter_cond_pkg::mem_packet_t    response_in,
    output logic                            response_full,
    output logic                            configure_setup,
    input  logic                            request_rd_en,
    output filter_cond_pkg::mem_packet_t    request_out,
    output logic                            done
);
    import filter_cond_pkg::*;

    descriptor_t     descriptor_reg;
    filter_config_t  config_reg;
    mem_packet_t     response_reg;
    fifo_flags_t     in_flags;
    fifo_flags_t     out_flags;
    mem_packet_t     popped_pkt;
    mem_packet_t     kernel_in;
    mem_packet_t     kernel_pkt;
    filter_param_t   param;
    logic            param_valid;
    logic            pop;
    logic            result_flag;
    logic            route_wr_en;
    packet_payload_t route_dout;
    logic            request_pop;

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        descriptor_reg <= descriptor_in;
        config_reg     <= config_in;
        response_reg   <= response_in;
        if (areset_generator) begin
            descriptor_reg.valid <= 1'b0;
            config_reg.valid     <= 1'b0;
            response_reg.valid   <= 1'b0;
        end
    end

    // Early full leaves room for the push still in the input register
    assign response_full = in_flags.prog_full;

    packet_fifo u_response_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (response_reg.valid),
        .din              (response_reg.payload),
        .rd_en            (pop),
        .dout             (popped_pkt),
        .flags            (in_flags)
    );

    filter_cond_control u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor       (descriptor_reg),
        .config_ready     (config_ready),
        .cfg              (config_reg),
        .in_flags         (in_flags),
        .out_flags        (out_flags),
        .kernel_valid     (kernel_pkt.valid),
        .route_valid      (route_wr_en),
        .popped_valid     (popped_pkt.valid),
        .configure_setup  (configure_setup),
        .param            (param),
        .param_valid      (param_valid),
        .pop              (pop),
        .done             (done)
    );

    // Compare only against a loaded configuration
    always_comb begin
        kernel_in       = popped_pkt;
        kernel_in.valid = popped_pkt.valid & param_valid;
    end

    filter_cond_kernel u_kernel (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .param            (param),
        .in_pkt           (kernel_in),
        .out_pkt          (kernel_pkt),
        .result_flag      (result_flag)
    );

    filter_cond_route u_route (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .param            (param),
        .in_pkt           (kernel_pkt),
        .result_flag      (result_flag),
        .wr_en            (route_wr_en),
        .dout             (route_dout)
    );

    // --------------------
    // Output FIFO
    // --------------------
    assign request_pop = request_rd_en & ~out_flags.empty;

    packet_fifo u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (route_wr_en),
        .din              (route_dout),
        .rd_en            (request_pop),
        .dout             (request_out),
        .flags            (out_flags)
    );

endmodule

`default_nettype wire

//--- testbench/tb_filter_cond_cases.svh
// --------------------
// Case table for the filter-condition engine testbench
// Included inside the testbench module after the package import
// --------------------
`ifndef TB_FILTER_COND_CASES_SVH
`define TB_FILTER_COND_CASES_SVH

localparam int NUM_CASES = 6;

// One job: configuration, packet stream and consumer stall level
typedef struct packed {
    filter_param_t param;
    logic [7:0]    count;
    logic [31:0]   data_base;
    logic [31:0]   data_step;
    logic [7:0]    to_id;
    logic [1:0]    stall_bits;
} case_entry_t;

case_entry_t case_table [NUM_CASES];

function automatic case_entry_t make_case(
    input cmp_op_t     op,
    input logic        signed_cmp,
    input logic [31:0] value,
    input logic        cond,
    input logic [7:0]  if_id,
    input logic [7:0]  else_id,
    input logic [7:0]  count,
    input logic [31:0] base,
    input logic [31:0] step,
    input logic [7:0]  to_id,
    input logic [1:0]  stall_bits
);
    case_entry_t c;
    c.param.op               = op;
    c.param.signed_cmp       = signed_cmp;
    c.param.value.u          = value;
    c.param.conditional_flag = cond;
    c.param.if_id            = if_id;
    c.param.else_id          = else_id;
    c.count                  = count;
    c.data_base              = base;
    c.data_step              = step;
    c.to_id                  = to_id;
    c.stall_bits             = stall_bits;
    return c;
endfunction

function automatic void fill_case_table();
    // Plain unsigned GT, values 95 to 104
    case_table[0] = make_case(CMP_GT, 1'b0, 32'd100, 1'b0, 8'h00, 8'h00,
                              8'd10, 32'd95, 32'd1, 8'h11, 2'd1);
    // Signed LT, data starts at -4
    case_table[1] = make_case(CMP_LT, 1'b1, 32'd5, 1'b0, 8'h00, 8'h00,
                              8'd7, 32'hFFFF_FFFC, 32'd2, 8'h22, 2'd0);
    // Same data read unsigned, negatives now fail
    case_table[2] = make_case(CMP_LT, 1'b0, 32'd5, 1'b0, 8'h00, 8'h00,
                              8'd7, 32'hFFFF_FFFC, 32'd2, 8'h33, 2'd0);
    // Conditional EQ, one packet takes the if-id
    case_table[3] = make_case(CMP_EQ, 1'b0, 32'd40, 1'b1, 8'hA1, 8'hB2,
                              8'd6, 32'd36, 32'd2, 8'h44, 2'd2);
    // Long NE run against a slow consumer
    case_table[4] = make_case(CMP_NE, 1'b0, 32'd7, 1'b0, 8'h00, 8'h00,
                              8'd20, 32'd0, 32'd1, 8'h55, 2'd3);
    case_table[5] = make_case(CMP_LT, 1'b0, 32'd1000, 1'b1, 8'hC3, 8'hD4,
                              8'd8, 32'd990, 32'd3, 8'h66, 2'd1);
endfunction

// Galois LFSR, 16 bits
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
endfunction

`endif

//--- testbench/tb_engine_filter_cond_generator.sv
// --------------------
// Testbench for the filter-condition engine
// Runs the case table through the DUT and checks every output packet
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_engine_filter_cond_generator;
    import filter_cond_pkg::*;

    `include "tb_filter_cond_cases.svh"

    logic            ap_clk;
    logic            areset_generator;
    descriptor_t     descriptor_in;
    logic            config_ready;
    filter_config_t  config_in;
    mem_packet_t     response_in;
    logic            response_full;
    logic            configure_setup;
    logic            request_rd_en;
    mem_packet_t     request_out;
    logic            done;

    packet_payload_t expected_q [$];
    logic [15:0]     lfsr_state;
    int              stall_bits;
    int              errors;
    int              checks;
    int              case_checks;
    int              setup_pulses;
    logic            config_sent;
    int              cycle_count;
    int              cycle_limit;

    engine_filter_cond_generator u_dut (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_in    (descriptor_in),
        .config_ready     (config_ready),
        .config_in        (config_in),
        .response_in      (response_in),
        .response_full    (response_full),
        .configure_setup  (configure_setup),
        .request_rd_en    (request_rd_en),
        .request_out      (request_out),
        .done             (done)
    );

    always begin
        #10 ap_clk = ~ap_clk;
    end

    // Reference compare on operands widened to 33 bits
    function automatic logic passes_filter(input filter_param_t p, input logic [31:0] d);
        logic signed [32:0] a;
        logic signed [32:0] b;
        a = p.signed_cmp ? {d[31], d} : {1'b0, d};
        b = p.signed_cmp ? {p.value.u[31], p.value.u} : {1'b0, p.value.u};
        case (p.op)
            CMP_EQ:  return a == b;
            CMP_NE:  return a != b;
            CMP_LT:  return a < b;
            default: return a > b;
        endcase
    endfunction

    // --------------------
    // Consumer with LFSR stalls
    // --------------------
    always @(posedge ap_clk) begin : consumer_drive
        logic ready;
        int   k;
        #2;
        ready = 1'b1;
        for (k = 0; k < stall_bits; k++) begin
            ready      = ready & lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        request_rd_en = ready;
    end

    // Scoreboard samples the outputs on the falling edge
    always @(negedge ap_clk) begin : output_check
        packet_payload_t exp;
        if (configure_setup) begin
            setup_pulses++;
        end
        if (request_out.valid) begin
            assert (config_sent) else begin
                $display("ERR %0t: packet left before the configuration was sent", $time);
                errors++;
            end
            assert (expected_q.size() > 0) else begin
                $display("ERR %0t: unexpected packet %h", $time, request_out.payload);
                errors++;
            end
            if (expected_q.size() > 0) begin
                exp = expected_q.pop_front();
                checks++;
                case_checks++;
                assert (request_out.payload == exp) else begin
                    $display("ERR %0t: got %h, expected %h", $time, request_out.payload, exp);
                    errors++;
                end
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // --------------------
    // One job from the table
    // --------------------
    task automatic run_case(input int idx);
        case_entry_t     c;
        packet_payload_t pkt;
        packet_payload_t exp;
        int              sent;
        int              start_errors;
        int              config_wait;
        c            = case_table[idx];
        start_errors = errors;
        case_checks  = 0;
        setup_pulses = 0;
        config_sent  = 1'b0;
        stall_bits   = int'(c.stall_bits);
        if (idx > 0) begin
            // Done must hold until the next descriptor
            repeat (3) @(negedge ap_clk);
            assert (done) else begin
                $display("ERR %0t: done dropped before the next descriptor", $time);
                errors++;
            end
        end
        @(posedge ap_clk);
        #2;
        descriptor_in.valid = 1'b1;
        descriptor_in.count = 16'(c.count);
        @(posedge ap_clk);
        #2;
        descriptor_in.valid = 1'b0;
        do begin
            @(negedge ap_clk);
        end while (!configure_setup);
        // Packets queue up in the DUT while the configuration is held back
        config_wait = 10 + idx;
        sent        = 0;
        while ((sent < int'(c.count)) || !config_sent) begin
            @(posedge ap_clk);
            #2;
            config_in.valid   = 1'b0;
            response_in.valid = 1'b0;
            assert (!done) else begin
                $display("ERR %0t: done high while packets are still being sent", $time);
                errors++;
            end
            if (!config_sent) begin
                if (config_wait == 0) begin
                    config_in.valid = 1'b1;
                    config_in.param = c.param;
                    config_sent     = 1'b1;
                end else begin
                    config_wait--;
                end
            end
            if ((sent < int'(c.count)) && !response_full) begin
                pkt.meta.to      = c.to_id;
                pkt.meta.from    = 8'(idx);
                pkt.meta.address = 16'h1000 + 16'(idx * 256 + sent);
                pkt.data.u       = c.data_base + c.data_step * 32'(sent);
                response_in.valid   = 1'b1;
                response_in.payload = pkt;
                exp = pkt;
                if (c.param.conditional_flag) begin
                    exp.meta.to = passes_filter(c.param, pkt.data.u) ? c.param.if_id
                                                                      : c.param.else_id;
                    expected_q.push_back(exp);
                end else if (passes_filter(c.param, pkt.data.u)) begin
                    expected_q.push_back(exp);
                end
                sent++;
            end
        end
        @(posedge ap_clk);
        #2;
        config_in.valid   = 1'b0;
        response_in.valid = 1'b0;
        while (!(done && expected_q.size() == 0)) begin
            @(negedge ap_clk);
        end
        assert (setup_pulses == 1) else begin
            $display("ERR %0t: %0d setup pulses for one descriptor", $time, setup_pulses);
            errors++;
        end
        $display("case %0d: %0d packets in, %0d out, %0d errors",
                 idx, c.count, case_checks, errors - start_errors);
    endtask

    initial begin
        ap_clk           = 1'b0;
        areset_generator = 1'b1;
        descriptor_in    = '0;
        config_ready     = 1'b0;
        config_in        = '0;
        response_in      = '0;
        request_rd_en    = 1'b0;
        lfsr_state       = 16'd83;
        stall_bits       = 0;
        errors           = 0;
        checks           = 0;
        case_checks      = 0;
        setup_pulses     = 0;
        config_sent      = 1'b0;
        cycle_count      = 0;
        fill_case_table();
        cycle_limit = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            cycle_limit += 40 + 8 * int'(case_table[i].count);
        end
        repeat (3) @(posedge ap_clk);
        #2;
        areset_generator = 1'b0;
        config_ready     = 1'b1;
        @(negedge ap_clk);
        assert (!done && !configure_setup && !request_out.valid && !response_full) else begin
            $display("ERR %0t: outputs not idle after reset", $time);
            errors++;
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        $display("cases %0d, checks %0d, errors %0d", NUM_CASES, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+testbench
source/filter_cond_pkg.sv
source/packet_fifo.sv
source/filter_cond_control.sv
source/filter_cond_kernel.sv
source/filter_cond_route.sv
source/engine_filter_cond_generator.sv
testbench/tb_engine_filter_cond_generator.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the filter-condition engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_engine_filter_cond_generator \
    -f list.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run_sim: test passed"
    exit 0
else
    echo "run_sim: test failed, see sim.log"
    exit 1
fi
